// ==== rv_cfg.svh ====
// Core sizing; RV_XLEN other than 32 is not supported by the RV32I field layout
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Data, address and instruction width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NUM_REGS 32

// First fetch address after ctrl_reset
`define RV_RESET_PC 32'h0000_0000

// No compressed instructions, so always one word
`define RV_INST_STEP 32'd4

`endif

// ==== rv_pkg.sv ====
// Types for the RV32I core; only the opcodes the core executes are named here
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

    // Major opcodes kept by this core, anything else decodes to no write
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    // funct3 codes of the integer ALU group
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000, // SUB when alu_alt
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRX  = 3'b101, // SRL, or SRA when alu_alt
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_func_t;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
// icache_data must be valid in the same cycle as icache_addr; no branch or jump redirect
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module fetch_stage (
    input  logic          ctrl_clk,
    input  logic          ctrl_reset,
    input  logic          icache_rdy,
    input  rv_pkg::word_t icache_data,
    output rv_pkg::word_t icache_addr,
    output rv_pkg::word_t inst,
    output rv_pkg::word_t pc,
    output logic          fetch_bubble
);

    rv_pkg::word_t pc_q; // Address of the next instruction to fetch

    assign icache_addr = pc_q;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            pc_q         <= `RV_RESET_PC;
            fetch_bubble <= 1'b1;
        end else if (icache_rdy) begin
            pc_q         <= pc_q + `RV_INST_STEP;
            fetch_bubble <= 1'b0;
        end else begin
            fetch_bubble <= 1'b1; // Port stalled, pass a bubble on
        end
    end

    // Instruction and its PC, qualified by fetch_bubble
    always_ff @(posedge ctrl_clk) begin
        if (icache_rdy) begin
            inst <= icache_data;
            pc   <= pc_q;
        end
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
// Write port trusts the caller to never strobe x0; no read-during-write bypass
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module register_file (
    input  logic             ctrl_clk,
    input  rv_pkg::reg_idx_t rs1_addr,
    input  rv_pkg::reg_idx_t rs2_addr,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    input  logic             wb_en,
    input  rv_pkg::reg_idx_t wb_addr,
    input  rv_pkg::word_t    wb_data
);

    rv_pkg::word_t regs [`RV_NUM_REGS];

    // x0 is hardwired on the read side
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge ctrl_clk) begin
        if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
// No hazard detection or forwarding; a reader must trail its writer by two instructions
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module decode_stage (
    input  logic              ctrl_clk,
    input  logic              ctrl_reset,
    input  rv_pkg::word_t     inst,
    input  rv_pkg::word_t     pc,
    input  logic              fetch_bubble,
    output rv_pkg::reg_idx_t  rs1_addr,
    output rv_pkg::reg_idx_t  rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     op_a,
    output rv_pkg::word_t     op_b,
    output rv_pkg::reg_idx_t  rd,
    output rv_pkg::alu_func_t alu_func,
    output logic              alu_alt,
    output logic              writes_rd,
    output logic              dec_bubble
);

    rv_pkg::opcode_t   opcode;
    logic [2:0]        funct3;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_u;
    logic              is_nop;
    rv_pkg::word_t     op_a_d;
    rv_pkg::word_t     op_b_d;
    rv_pkg::alu_func_t func_d;
    logic              alt_d;
    logic              wr_d;

    assign opcode   = rv_pkg::opcode_t'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};

    // addi x0, x0, 0 and friends
    assign is_nop = (opcode == rv_pkg::OPC_OP_IMM) && (inst[31:7] == '0);

    always_comb begin
        op_a_d = rs1_data;
        op_b_d = rs2_data;
        func_d = rv_pkg::alu_func_t'(funct3);
        alt_d  = 1'b0;
        wr_d   = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                alt_d = inst[30]; // SUB, SRA
                wr_d  = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                op_b_d = imm_i;
                // Bit 30 is immediate data except for SRAI
                alt_d  = (funct3 == rv_pkg::ALU_SRX) && inst[30];
                wr_d   = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                op_a_d = imm_u;
                op_b_d = '0;
                func_d = rv_pkg::ALU_ADD;
                wr_d   = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                op_a_d = imm_u;
                op_b_d = pc;
                func_d = rv_pkg::ALU_ADD;
                wr_d   = 1'b1;
            end
            default: begin
                wr_d = 1'b0; // Branches, loads, stores, system
            end
        endcase
    end

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            dec_bubble <= 1'b1;
            writes_rd  <= 1'b0;
        end else begin
            dec_bubble <= fetch_bubble || is_nop;
            writes_rd  <= wr_d;
        end
    end

    always_ff @(posedge ctrl_clk) begin
        op_a     <= op_a_d;
        op_b     <= op_b_d;
        rd       <= inst[11:7];
        alu_func <= func_d;
        alu_alt  <= alt_d;
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
// Single-cycle ALU; wb_en is never raised for x0, which the register file relies on
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module execute_stage (
    input  logic              ctrl_clk,
    input  logic              ctrl_reset,
    input  rv_pkg::word_t     op_a,
    input  rv_pkg::word_t     op_b,
    input  rv_pkg::reg_idx_t  rd,
    input  rv_pkg::alu_func_t alu_func,
    input  logic              alu_alt,
    input  logic              writes_rd,
    input  logic              dec_bubble,
    output logic              wb_en,
    output rv_pkg::reg_idx_t  wb_addr,
    output rv_pkg::word_t     wb_data
);

    logic [4:0]    shamt;
    rv_pkg::word_t alu_res;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_func)
            rv_pkg::ALU_ADD:  alu_res = alu_alt ? op_a - op_b : op_a + op_b;
            rv_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv_pkg::ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_pkg::ALU_SRX: begin
                // Kept apart so the arithmetic shift stays signed
                if (alu_alt) begin
                    alu_res = $signed(op_a) >>> shamt;
                end else begin
                    alu_res = op_a >> shamt;
                end
            end
            rv_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv_pkg::ALU_AND:  alu_res = op_a & op_b;
            default:          alu_res = '0;
        endcase
    end

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= !dec_bubble && writes_rd && (rd != '0);
        end
    end

    always_ff @(posedge ctrl_clk) begin
        wb_addr <= rd;
        wb_data <= alu_res; // Only meaningful with wb_en
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
// Four-stage RV32I ALU subset; only icache_rdy stalls, and stalls become bubbles
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  logic             ctrl_clk,
    input  logic             ctrl_reset,
    output rv_pkg::word_t    icache_addr,
    input  rv_pkg::word_t    icache_data,
    input  logic             icache_rdy,
    output logic             wb_en,
    output rv_pkg::reg_idx_t wb_addr,
    output rv_pkg::word_t    wb_data
);

    // Fetch to decode
    rv_pkg::word_t     inst;
    rv_pkg::word_t     pc;
    logic              fetch_bubble;

    // Decode and register file
    rv_pkg::reg_idx_t  rs1_addr;
    rv_pkg::reg_idx_t  rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    // Decode to execute
    rv_pkg::word_t     op_a;
    rv_pkg::word_t     op_b;
    rv_pkg::reg_idx_t  rd;
    rv_pkg::alu_func_t alu_func;
    logic              alu_alt;
    logic              writes_rd;
    logic              dec_bubble;

    fetch_stage i_fetch_stage (
        .ctrl_clk     (ctrl_clk),
        .ctrl_reset   (ctrl_reset),
        .icache_rdy   (icache_rdy),
        .icache_data  (icache_data),
        .icache_addr  (icache_addr),
        .inst         (inst),
        .pc           (pc),
        .fetch_bubble (fetch_bubble)
    );

    decode_stage i_decode_stage (
        .ctrl_clk     (ctrl_clk),
        .ctrl_reset   (ctrl_reset),
        .inst         (inst),
        .pc           (pc),
        .fetch_bubble (fetch_bubble),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .op_a         (op_a),
        .op_b         (op_b),
        .rd           (rd),
        .alu_func     (alu_func),
        .alu_alt      (alu_alt),
        .writes_rd    (writes_rd),
        .dec_bubble   (dec_bubble)
    );

    register_file i_register_file (
        .ctrl_clk (ctrl_clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    execute_stage i_execute_stage (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .op_a       (op_a),
        .op_b       (op_b),
        .rd         (rd),
        .alu_func   (alu_func),
        .alu_alt    (alu_alt),
        .writes_rd  (writes_rd),
        .dec_bubble (dec_bubble),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

endmodule

`default_nettype wire

// ==== rv_core_checker.sv ====
// Bound into rv_core; assumes the fixed three-edge latency from accept to write strobe
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core_checker (
    input logic             ctrl_clk,
    input logic             ctrl_reset,
    input rv_pkg::word_t    icache_addr,
    input logic             icache_rdy,
    input logic             wb_en,
    input rv_pkg::reg_idx_t wb_addr
);

    int unsigned assert_fails = 0;

    reset_state: assert property (@(posedge ctrl_clk)
        ctrl_reset |=> !wb_en && icache_addr == `RV_RESET_PC)
        else begin assert_fails++; $error("reset state wrong"); end

    pc_step: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        icache_rdy |=> icache_addr == $past(icache_addr) + `RV_INST_STEP)
        else begin assert_fails++; $error("PC did not step on accept"); end

    pc_hold: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        !icache_rdy |=> $stable(icache_addr))
        else begin assert_fails++; $error("PC moved during stall"); end

    no_x0_write: assert property (@(posedge ctrl_clk)
        wb_en |-> wb_addr != '0)
        else begin assert_fails++; $error("write strobe for x0"); end

    // A write needs an accepted instruction exactly three edges back
    wb_latency: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        wb_en |-> $past(icache_rdy, 3))
        else begin assert_fails++; $error("write without accept three edges earlier"); end

endmodule

bind rv_core rv_core_checker i_rv_core_checker (
    .ctrl_clk    (ctrl_clk),
    .ctrl_reset  (ctrl_reset),
    .icache_addr (icache_addr),
    .icache_rdy  (icache_rdy),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr)
);

`default_nettype wire

// ==== tb_rv_core.sv ====
// Program obeys the two-instruction spacing rule; stalls from icache_rdy are random
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_core;

    localparam int PROG_LEN = 26;

    logic             ctrl_clk = 1'b0;
    logic             ctrl_reset;
    rv_pkg::word_t    icache_addr;
    rv_pkg::word_t    icache_data;
    logic             icache_rdy;
    logic             wb_en;
    rv_pkg::reg_idx_t wb_addr;
    rv_pkg::word_t    wb_data;

    logic [31:0] prog [PROG_LEN];
    logic [31:0] gold [32];
    logic [31:0] lcg_state = 32'h1955_7e28;
    int          cyc = 0;
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    int          exp_cyc [$];
    int          exp_idx [$];

    rv_core i_rv_core (.*);

    always #50 ctrl_clk = ~ctrl_clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic next_ready();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:30] != 2'b00; // About three accepts in four
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // Architectural result of one accepted instruction
    task automatic predict(input logic [31:0] w, input logic [31:0] pc, input int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        wr;
        logic        is_op;
        is_op = (w[6:0] == 7'b0110011);
        a  = gold[w[19:15]];
        b  = is_op ? gold[w[24:20]] : {{20{w[31]}}, w[31:20]};
        wr = 1'b1;
        r  = '0;
        case (w[6:0])
            7'b0110111: r = {w[31:12], 12'b0};
            7'b0010111: r = {w[31:12], 12'b0} + pc;
            7'b0110011, 7'b0010011: begin
                case (w[14:12])
                    3'd0: r = (is_op && w[30]) ? a - b : a + b;
                    3'd1: r = a << b[4:0];
                    3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3: r = (a < b) ? 32'd1 : 32'd0;
                    3'd4: r = a ^ b;
                    3'd5: r = w[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6: r = a | b;
                    default: r = a & b;
                endcase
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            gold[w[11:7]] = r;
            exp_rd.push_back(w[11:7]);
            exp_val.push_back(r);
            exp_cyc.push_back(cyc + 3);
            exp_idx.push_back(idx);
        end
    endtask

    assign icache_data = (icache_addr < PROG_LEN * 4) ? prog[icache_addr[6:2]] : 32'h0000_0013;

    always @(posedge ctrl_clk) begin
        cyc++;
        if (!ctrl_reset && wb_en) begin
            if (exp_rd.size() == 0) begin
                fail_now($sformatf("Write to x%0d with no instruction pending", wb_addr));
            end else if (wb_addr !== exp_rd[0] || wb_data !== exp_val[0]
                         || cyc != exp_cyc[0]) begin
                fail_now($sformatf("MISMATCH inst_%0d: expected x%0d=%h @%0d, actual x%0d=%h @%0d",
                                   exp_idx[0], exp_rd[0], exp_val[0], exp_cyc[0],
                                   wb_addr, wb_data, cyc));
            end else begin
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
                void'(exp_cyc.pop_front());
                void'(exp_idx.pop_front());
            end
        end
        if (!ctrl_reset && icache_rdy) begin
            predict(icache_data, icache_addr, icache_addr / 4);
        end
        if (i_rv_core.i_rv_core_checker.assert_fails != 0) begin
            fail_now("A protocol assertion failed");
        end
    end

    initial begin
        int t;
        prog = '{
            u_type(20'h80001, 5'd1, 7'b0110111), i_type(12'hFFB, 5'd0, 3'd0, 5'd2),
            i_type(12'h123, 5'd0, 3'd0, 5'd3),   u_type(20'h12345, 5'd4, 7'b0010111),
            i_type(12'h007, 5'd1, 3'd0, 5'd5),   r_type(7'h20, 5'd3, 5'd2, 3'd0, 5'd6),
            r_type(7'h00, 5'd2, 5'd1, 3'd2, 5'd7), r_type(7'h00, 5'd2, 5'd1, 3'd3, 5'd8),
            r_type(7'h00, 5'd3, 5'd1, 3'd4, 5'd9), r_type(7'h00, 5'd3, 5'd2, 3'd6, 5'd10),
            r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd11), r_type(7'h00, 5'd2, 5'd3, 3'd1, 5'd12),
            r_type(7'h00, 5'd3, 5'd1, 3'd5, 5'd13), r_type(7'h20, 5'd3, 5'd1, 3'd5, 5'd14),
            i_type(12'hFFC, 5'd2, 3'd2, 5'd15),  i_type(12'h001, 5'd2, 3'd3, 5'd16),
            i_type(12'hFFF, 5'd3, 3'd4, 5'd17),  i_type(12'h055, 5'd1, 3'd6, 5'd18),
            i_type(12'h0F0, 5'd2, 3'd7, 5'd19),  i_type(12'h004, 5'd3, 3'd1, 5'd20),
            i_type(12'h008, 5'd1, 3'd5, 5'd21),  i_type(12'h408, 5'd1, 3'd5, 5'd22),
            r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd23),
            i_type(12'h005, 5'd1, 3'd0, 5'd0),   32'h0020_8463, // x0 target, then beq
            32'h0020_a223                                      // sw, never written back
        };
        foreach (gold[i]) gold[i] = '0;
        ctrl_reset = 1'b1;
        icache_rdy = 1'b0;
        repeat (4) @(posedge ctrl_clk);
        #1 ctrl_reset = 1'b0;
        t = 0;
        while (icache_addr < PROG_LEN * 4) begin
            @(posedge ctrl_clk);
            #1 icache_rdy = next_ready();
            t++;
            if (t > 400) fail_now("Timeout while fetching the program");
        end
        t = 0;
        while (exp_rd.size() != 0) begin
            @(posedge ctrl_clk);
            #1 icache_rdy = next_ready();
            t++;
            if (t > 20) fail_now("Timeout waiting for the last write-backs");
        end
        repeat (6) begin // NOPs keep flowing, no write may appear
            @(posedge ctrl_clk);
            #1 icache_rdy = 1'b1;
        end
        if (exp_rd.size() == 0 && i_rv_core.i_rv_core_checker.assert_fails == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_now("Pending writes or assertion failures at the end");
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
rv_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
rv_core.sv
rv_core_checker.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
